//--- src/fuse_filter_cfg.svh
// Fixed three-entry access table and 8-bit register offsets; ranges are inclusive fuse addresses.
`ifndef FUSE_FILTER_CFG_SVH
`define FUSE_FILTER_CFG_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define FUSE_REG_AW 8
`define FUSE_USER_W 32
`define FUSE_ADDR_W 32

// Direct-access register offsets within the fuse controller window.
`define FUSE_OFS_CMD     8'h60
`define FUSE_OFS_ADDRESS 8'h64
`define FUSE_OFS_WDATA0  8'h68
`define FUSE_OFS_WDATA1  8'h6C

// Command codes as written to the command register.
`define FUSE_CMD_READ    32'h0000_0001
`define FUSE_CMD_WRITE   32'h0000_0002
`define FUSE_CMD_DIGEST  32'h0000_0004
`define FUSE_CMD_ZEROIZE 32'h0000_0008

// ----------------------------------------
// Access-control table
// ----------------------------------------
`define FUSE_TBL_N 3

// Entry 0 is owned by the security core, entries 1 and 2 by the microcontroller.
`define FUSE_TBL0_LO 32'h0000_0000
`define FUSE_TBL0_HI 32'h0000_00FF
`define FUSE_TBL1_LO 32'h0000_0100
`define FUSE_TBL1_HI 32'h0000_03FF
`define FUSE_TBL2_LO 32'h0000_0400
`define FUSE_TBL2_HI 32'h0000_07FF

// Secret fuses, where zeroization needs the FIPS override.
`define FUSE_SECRET_LO 32'h0000_0040
`define FUSE_SECRET_HI 32'h0000_007F

`endif

//--- src/fuse_filter_pkg.sv
// Types only; the bus view carries just the write-channel fields the filter observes.
`include "fuse_filter_cfg.svh"

package fuse_filter_pkg;

    typedef logic [`FUSE_REG_AW-1:0] reg_ofs_t;
    typedef logic [`FUSE_USER_W-1:0] axi_user_t;
    typedef logic [`FUSE_ADDR_W-1:0] fuse_addr_t;

    // Command word written to the command register.
    typedef enum logic [`FUSE_ADDR_W-1:0] {
        DAI_READ    = `FUSE_CMD_READ,
        DAI_WRITE   = `FUSE_CMD_WRITE,
        DAI_DIGEST  = `FUSE_CMD_DIGEST,
        DAI_ZEROIZE = `FUSE_CMD_ZEROIZE
    } dai_cmd_e;

    typedef enum logic [2:0] {
        RESET_ST,
        IDLE_ST,
        WDATA_ADDR_ST,
        WDATA_ST,
        FUSE_ADDR_AXI_ADDR_ST,
        FUSE_ADDR_AXI_WR_ST,
        FUSE_CMD_AXI_ADDR_ST,
        DISCARD_ST
    } filter_state_e;

    // ----------------------------------------
    // Structs passed between the blocks
    // ----------------------------------------
    typedef struct packed {
        logic       awvalid;
        logic       awready;
        reg_ofs_t   awaddr;
        axi_user_t  awuser;
        logic       wvalid;
        logic       wready;
        fuse_addr_t wdata;
    } axi_obs_t;

    typedef struct packed {
        logic wdata0_aw;
        logic wdata1_aw;
        logic address_aw;
        logic cmd_aw;
        logic w_event;
        logic any_aw;
    } seq_evt_t;

    typedef struct packed {
        logic data0;
        logic data1;
        logic addr_id;
        logic cmd_id;
        logic fuse_addr;
    } latch_ctl_t;

    typedef struct packed {
        logic all_same_id;
        logic addr_cmd_same_id;
        logic secret_access;
    } id_status_t;

endpackage

//--- src/fuse_axi_decode.sv
// Purely combinational; an address hit needs awvalid and awready high in the same cycle.
`timescale 1ns/1ps
`include "fuse_filter_cfg.svh"

module fuse_axi_decode (
    input  fuse_filter_pkg::axi_obs_t core_wr_i,
    output fuse_filter_pkg::seq_evt_t evt_o
);
    import fuse_filter_pkg::*;

    logic     aw_hs;
    logic     w_hs;
    reg_ofs_t aw_ofs;
    logic     hit_wdata0;
    logic     hit_wdata1;
    logic     hit_address;
    logic     hit_cmd;

    // Handshakes on the two observed channels.
    assign aw_hs  = core_wr_i.awvalid && core_wr_i.awready;
    assign w_hs   = core_wr_i.wvalid && core_wr_i.wready;
    assign aw_ofs = core_wr_i.awaddr;

    // ----------------------------------------
    // Register map hits
    // ----------------------------------------
    assign hit_wdata0  = aw_hs && (aw_ofs == reg_ofs_t'(`FUSE_OFS_WDATA0));
    assign hit_wdata1  = aw_hs && (aw_ofs == reg_ofs_t'(`FUSE_OFS_WDATA1));
    assign hit_address = aw_hs && (aw_ofs == reg_ofs_t'(`FUSE_OFS_ADDRESS));
    assign hit_cmd     = aw_hs && (aw_ofs == reg_ofs_t'(`FUSE_OFS_CMD));

    assign evt_o.wdata0_aw  = hit_wdata0;
    assign evt_o.wdata1_aw  = hit_wdata1;
    assign evt_o.address_aw = hit_address;
    assign evt_o.cmd_aw     = hit_cmd;

    // Data beats are not tied to an offset; the state machine knows which phase it is in.
    assign evt_o.w_event = w_hs;

    // Offsets are distinct, so at most one hit is set in any cycle.
    assign evt_o.any_aw = hit_wdata0 || hit_wdata1 || hit_address || hit_cmd;

endmodule

//--- src/fuse_id_tracker.sv
// Holds IDs and fuse address across sequences; only clear_i or reset wipes them.
`timescale 1ns/1ps
`include "fuse_filter_cfg.svh"

module fuse_id_tracker (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clear_i,
    input  fuse_filter_pkg::latch_ctl_t  latch_i,
    input  fuse_filter_pkg::axi_obs_t    core_wr_i,
    output fuse_filter_pkg::fuse_addr_t  fuse_addr_o,
    output fuse_filter_pkg::axi_user_t   cmd_id_o,
    output fuse_filter_pkg::id_status_t  status_o
);
    import fuse_filter_pkg::*;

    axi_user_t  data0_id_q;
    axi_user_t  data1_id_q;
    axi_user_t  addr_id_q;
    axi_user_t  cmd_id_q;
    fuse_addr_t fuse_addr_q;
    logic       secret_q;
    logic       wdata_in_secret;

    // The secret check looks at the data beat itself, so the flag is ready
    // in the same cycle as the latched address.
    assign wdata_in_secret = (core_wr_i.wdata >= fuse_addr_t'(`FUSE_SECRET_LO)) &&
                             (core_wr_i.wdata <= fuse_addr_t'(`FUSE_SECRET_HI));

    // ----------------------------------------
    // ID and address records
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data0_id_q  <= '0;
            data1_id_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_q    <= '0;
            fuse_addr_q <= '0;
            secret_q    <= 1'b0;
        end else if (clear_i) begin
            data0_id_q  <= '0;
            data1_id_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_q    <= '0;
            fuse_addr_q <= '0;
            secret_q    <= 1'b0;
        end else begin
            if (latch_i.data0) begin
                data0_id_q <= core_wr_i.awuser;
            end
            if (latch_i.data1) begin
                data1_id_q <= core_wr_i.awuser;
            end
            if (latch_i.addr_id) begin
                addr_id_q <= core_wr_i.awuser;
            end
            if (latch_i.cmd_id) begin
                cmd_id_q <= core_wr_i.awuser;
            end
            if (latch_i.fuse_addr) begin
                fuse_addr_q <= core_wr_i.wdata;
                secret_q    <= wdata_in_secret;
            end
        end
    end

    // ----------------------------------------
    // Consistency results
    // ----------------------------------------
    // The second data word only matters for secret fuses, which are written 64 bits wide.
    assign status_o.all_same_id      = (data0_id_q == addr_id_q) &&
                                       (addr_id_q == cmd_id_q) &&
                                       (!secret_q || (data1_id_q == data0_id_q));
    assign status_o.addr_cmd_same_id = (addr_id_q == cmd_id_q);
    assign status_o.secret_access    = secret_q;

    assign fuse_addr_o = fuse_addr_q;
    assign cmd_id_o    = cmd_id_q;

endmodule

//--- src/fuse_access_table.sv
// Table ranges are fixed by macros; only the owning user IDs come from straps at run time.
`timescale 1ns/1ps
`include "fuse_filter_cfg.svh"

module fuse_access_table (
    input  fuse_filter_pkg::fuse_addr_t fuse_addr_i,
    input  fuse_filter_pkg::axi_user_t  cmd_id_i,
    input  fuse_filter_pkg::axi_user_t  strap_cptra_user_i,
    input  fuse_filter_pkg::axi_user_t  strap_mcu_user_i,
    output logic                        wr_allowed_o
);
    import fuse_filter_pkg::*;

    axi_user_t  [`FUSE_TBL_N-1:0] tbl_user;
    fuse_addr_t [`FUSE_TBL_N-1:0] tbl_lo;
    fuse_addr_t [`FUSE_TBL_N-1:0] tbl_hi;
    logic       [`FUSE_TBL_N-1:0] entry_hit;

    // Entry list with owner and inclusive bounds.
    always_comb begin
        tbl_user[0] = strap_cptra_user_i;
        tbl_lo[0]   = `FUSE_TBL0_LO;
        tbl_hi[0]   = `FUSE_TBL0_HI;
        tbl_user[1] = strap_mcu_user_i;
        tbl_lo[1]   = `FUSE_TBL1_LO;
        tbl_hi[1]   = `FUSE_TBL1_HI;
        tbl_user[2] = strap_mcu_user_i;
        tbl_lo[2]   = `FUSE_TBL2_LO;
        tbl_hi[2]   = `FUSE_TBL2_HI;
    end

    // An entry matches when the address is inside its range and the
    // command was issued by the entry's owner.
    for (genvar i = 0; i < `FUSE_TBL_N; i++) begin : g_entry
        assign entry_hit[i] = (fuse_addr_i >= tbl_lo[i]) &&
                              (fuse_addr_i <= tbl_hi[i]) &&
                              (cmd_id_i == tbl_user[i]);
    end

    assign wr_allowed_o = |entry_hit;

endmodule

//--- src/fuse_filter_fsm.sv
// Tracks one programming sequence at a time; events seen in RESET_ST are ignored.
`timescale 1ns/1ps
`include "fuse_filter_cfg.svh"

module fuse_filter_fsm (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        fc_init_done_i,
    input  logic                        fips_zeroization_i,
    input  fuse_filter_pkg::seq_evt_t   evt_i,
    input  fuse_filter_pkg::dai_cmd_e   cmd_i,
    input  fuse_filter_pkg::id_status_t status_i,
    input  logic                        wr_allowed_i,
    input  logic                        discarded_fuse_write_i,
    output fuse_filter_pkg::latch_ctl_t latch_o,
    output logic                        clear_o,
    output logic                        discard_fuse_write_o
);
    import fuse_filter_pkg::*;

    filter_state_e state_q;
    filter_state_e state_d;
    filter_state_e aw_next;
    latch_ctl_t    aw_latch;
    logic          cmd_reject;
    logic          discard_q;

    // ----------------------------------------
    // Address-phase dispatch
    // ----------------------------------------
    // Shared by every state that may start a new register write. The hits
    // are exclusive, so the priority order has no effect.
    always_comb begin
        aw_latch = '0;
        aw_next  = IDLE_ST;
        if (evt_i.wdata0_aw) begin
            aw_latch.data0 = 1'b1;
            aw_next        = WDATA_ADDR_ST;
        end else if (evt_i.wdata1_aw) begin
            aw_latch.data1 = 1'b1;
            aw_next        = WDATA_ADDR_ST;
        end else if (evt_i.address_aw) begin
            aw_latch.addr_id = 1'b1;
            aw_next          = FUSE_ADDR_AXI_ADDR_ST;
        end else if (evt_i.cmd_aw) begin
            aw_latch.cmd_id = 1'b1;
            aw_next         = FUSE_CMD_AXI_ADDR_ST;
        end
    end

    // ----------------------------------------
    // Command rules
    // ----------------------------------------
    always_comb begin
        case (cmd_i)
            DAI_READ, DAI_DIGEST: begin
                cmd_reject = !wr_allowed_i || !status_i.addr_cmd_same_id;
            end
            DAI_WRITE: begin
                cmd_reject = !wr_allowed_i || !status_i.all_same_id;
            end
            DAI_ZEROIZE: begin
                // Secret fuses may only be zeroized under the FIPS override.
                cmd_reject = (status_i.secret_access && !fips_zeroization_i) ||
                             !wr_allowed_i || !status_i.addr_cmd_same_id;
            end
            default: begin
                cmd_reject = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // Next state and latch strobes
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        latch_o = '0;
        case (state_q)
            RESET_ST: begin
                if (fc_init_done_i) begin
                    state_d = IDLE_ST;
                end
            end
            IDLE_ST, WDATA_ST, FUSE_ADDR_AXI_WR_ST: begin
                if (evt_i.any_aw) begin
                    state_d = aw_next;
                    latch_o = aw_latch;
                end
            end
            WDATA_ADDR_ST: begin
                if (evt_i.w_event) begin
                    state_d = WDATA_ST;
                end
            end
            FUSE_ADDR_AXI_ADDR_ST: begin
                // The data beat carries the fuse address.
                if (evt_i.w_event) begin
                    latch_o.fuse_addr = 1'b1;
                    state_d           = FUSE_ADDR_AXI_WR_ST;
                end
            end
            FUSE_CMD_AXI_ADDR_ST: begin
                if (evt_i.w_event) begin
                    state_d = cmd_reject ? DISCARD_ST : IDLE_ST;
                end
            end
            DISCARD_ST: begin
                if (discarded_fuse_write_i) begin
                    state_d = IDLE_ST;
                end
            end
            default: begin
                state_d = IDLE_ST;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= RESET_ST;
            discard_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            // Request follows the discard state with one cycle of delay.
            discard_q <= (state_q == DISCARD_ST);
        end
    end

    assign clear_o              = (state_q == RESET_ST);
    assign discard_fuse_write_o = discard_q;

endmodule

//--- src/fuse_filter_top.sv
// Observes the core write channel only and never stalls it; discard is a level held until acked.
`timescale 1ns/1ps
`include "fuse_filter_cfg.svh"

module fuse_filter_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       fc_init_done_i,
    input  logic                       fips_zeroization_i,
    input  fuse_filter_pkg::axi_user_t strap_cptra_user_i,
    input  fuse_filter_pkg::axi_user_t strap_mcu_user_i,
    input  fuse_filter_pkg::axi_obs_t  core_wr_i,
    input  logic                       discarded_fuse_write_i,
    output logic                       discard_fuse_write_o
);
    import fuse_filter_pkg::*;

    seq_evt_t   evt;
    latch_ctl_t latch;
    logic       clear;
    fuse_addr_t fuse_addr;
    axi_user_t  cmd_id;
    id_status_t status;
    logic       wr_allowed;
    dai_cmd_e   fuse_cmd;

    // The command beat's data word is the command code.
    assign fuse_cmd = dai_cmd_e'(core_wr_i.wdata);

    fuse_axi_decode u_decode (
        .core_wr_i (core_wr_i),
        .evt_o     (evt)
    );

    fuse_id_tracker u_tracker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (clear),
        .latch_i     (latch),
        .core_wr_i   (core_wr_i),
        .fuse_addr_o (fuse_addr),
        .cmd_id_o    (cmd_id),
        .status_o    (status)
    );

    fuse_access_table u_table (
        .fuse_addr_i        (fuse_addr),
        .cmd_id_i           (cmd_id),
        .strap_cptra_user_i (strap_cptra_user_i),
        .strap_mcu_user_i   (strap_mcu_user_i),
        .wr_allowed_o       (wr_allowed)
    );

    fuse_filter_fsm u_fsm (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .fc_init_done_i         (fc_init_done_i),
        .fips_zeroization_i     (fips_zeroization_i),
        .evt_i                  (evt),
        .cmd_i                  (fuse_cmd),
        .status_i               (status),
        .wr_allowed_i           (wr_allowed),
        .discarded_fuse_write_i (discarded_fuse_write_i),
        .latch_o                (latch),
        .clear_o                (clear),
        .discard_fuse_write_o   (discard_fuse_write_o)
    );

endmodule

//--- testbench/fuse_filter_chk.sv
// Sampled on the rising clock and idle during reset; bound into every state machine instance.
`timescale 1ns/1ps

module fuse_filter_chk (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input fuse_filter_pkg::filter_state_e state_i,
    input fuse_filter_pkg::seq_evt_t      evt_i,
    input logic                           discarded_fuse_write_i,
    input logic                           discard_i
);
    import fuse_filter_pkg::*;

    int fail_count = 0;

    // No request may be pending before the fuse controller is initialized.
    a_quiet_in_reset : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == RESET_ST) |-> !discard_i)
    else begin
        fail_count++;
        $error("discard request high in RESET_ST");
    end

    // The request falls one cycle after the acknowledgement, never earlier.
    a_hold_until_ack : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (discard_i && !discarded_fuse_write_i && !$past(discarded_fuse_write_i)) |=> discard_i)
    else begin
        fail_count++;
        $error("discard request dropped before acknowledgement");
    end

    a_discard_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((state_i != DISCARD_ST) && !((state_i == FUSE_CMD_AXI_ADDR_ST) && evt_i.w_event))
        |=> (state_i != DISCARD_ST))
    else begin
        fail_count++;
        $error("DISCARD_ST entered without a command write event");
    end

endmodule

bind fuse_filter_fsm fuse_filter_chk u_chk (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .state_i                (state_q),
    .evt_i                  (evt_i),
    .discarded_fuse_write_i (discarded_fuse_write_i),
    .discard_i              (discard_fuse_write_o)
);

//--- testbench/tb_fuse_filter.sv
// Drives complete register writes only, one sequence at a time; the discard level is compared every cycle.
`timescale 1ns/1ps
`include "fuse_filter_cfg.svh"

module tb_fuse_filter;
    import fuse_filter_pkg::*;

    localparam int        N_DIRECTED = 11;
    localparam int        N_RANDOM   = 200;
    localparam int        MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;
    localparam axi_user_t CPTRA_USER = 32'h1111_0001;
    localparam axi_user_t MCU_USER   = 32'h2222_0002;
    localparam axi_user_t ROGUE_USER = 32'h3333_0003;

    logic       clk;
    logic       rst_n;
    logic       fc_init_done;
    logic       fips;
    logic       ack;
    logic       discard;
    logic       exp_disc;
    axi_obs_t   core_wr;
    integer     seed;
    int         cycles;

    // Model of what the filter should hold after each register write.
    axi_user_t  m_data0_id;
    axi_user_t  m_data1_id;
    axi_user_t  m_addr_id;
    axi_user_t  m_cmd_id;
    fuse_addr_t m_faddr;

    fuse_filter_top dut0 (
        .clk_i                  (clk),
        .rst_n_i                (rst_n),
        .fc_init_done_i         (fc_init_done),
        .fips_zeroization_i     (fips),
        .strap_cptra_user_i     (CPTRA_USER),
        .strap_mcu_user_i       (MCU_USER),
        .core_wr_i              (core_wr),
        .discarded_fuse_write_i (ack),
        .discard_fuse_write_o   (discard)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // Reference model and check
    // ----------------------------------------
    function automatic logic expected_discard(input fuse_addr_t cmd, input logic fips_on);
        logic secret;
        logic allowed;
        logic ids_ok;
        logic result;
        secret  = (m_faddr >= `FUSE_SECRET_LO) && (m_faddr <= `FUSE_SECRET_HI);
        // Entries 1 and 2 share an owner and are contiguous.
        allowed = ((m_faddr <= `FUSE_TBL0_HI) && (m_cmd_id == CPTRA_USER)) ||
                  ((m_faddr >= `FUSE_TBL1_LO) && (m_faddr <= `FUSE_TBL2_HI) &&
                   (m_cmd_id == MCU_USER));
        ids_ok  = (m_data0_id == m_addr_id) && (m_addr_id == m_cmd_id) &&
                  (!secret || (m_data1_id == m_data0_id));
        case (cmd)
            `FUSE_CMD_READ, `FUSE_CMD_DIGEST: result = !allowed || (m_addr_id != m_cmd_id);
            `FUSE_CMD_WRITE:                  result = !allowed || !ids_ok;
            `FUSE_CMD_ZEROIZE: begin
                result = (secret && !fips_on) || !allowed || (m_addr_id != m_cmd_id);
            end
            default:                          result = 1'b0;
        endcase
        expected_discard = result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    always @(negedge clk) begin
        check_value("discard_fuse_write_o", discard, exp_disc);
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // Valid is raised with ready low for the stall cycles, so no handshake happens there.
    task automatic write_reg(input reg_ofs_t ofs, input axi_user_t user, input fuse_addr_t data,
                             input int stall);
        core_wr.awvalid = 1'b1;
        core_wr.awaddr  = ofs;
        // A user ID seen while the address beat is stalled must never be recorded.
        core_wr.awuser  = ~user;
        repeat (stall) tick();
        core_wr.awuser  = user;
        core_wr.awready = 1'b1;
        tick();
        core_wr.awvalid = 1'b0;
        core_wr.awready = 1'b0;
        core_wr.wvalid  = 1'b1;
        core_wr.wdata   = data;
        repeat (stall) tick();
        core_wr.wready = 1'b1;
        tick();
        core_wr.wvalid = 1'b0;
        core_wr.wready = 1'b0;
    endtask

    task automatic clear_model();
        m_data0_id = '0;
        m_data1_id = '0;
        m_addr_id  = '0;
        m_cmd_id   = '0;
        m_faddr    = '0;
    endtask

    // Mask bit 0 writes data word 0, bit 1 data word 1, bit 2 the fuse address.
    task automatic run_seq(input logic [2:0] mask, input axi_user_t u0, input axi_user_t u1,
                           input axi_user_t ua, input axi_user_t uc, input fuse_addr_t faddr,
                           input fuse_addr_t cmd, input int stall);
        logic exp;
        if (mask[0]) begin
            write_reg(`FUSE_OFS_WDATA0, u0, $random(seed), stall);
            m_data0_id = u0;
        end
        if (mask[1]) begin
            write_reg(`FUSE_OFS_WDATA1, u1, $random(seed), stall);
            m_data1_id = u1;
        end
        if (mask[2]) begin
            write_reg(`FUSE_OFS_ADDRESS, ua, faddr, stall);
            m_addr_id = ua;
            m_faddr   = faddr;
        end
        write_reg(`FUSE_OFS_CMD, uc, cmd, stall);
        m_cmd_id = uc;
        exp = fc_init_done && expected_discard(cmd, fips);
        tick();
        exp_disc = exp;
        if (exp) begin
            // Hold off the acknowledgement so the request has to persist.
            repeat (2) tick();
            ack = 1'b1;
            tick();
            ack = 1'b0;
            tick();
            exp_disc = 1'b0;
        end
    endtask

    function automatic axi_user_t pick_user(input axi_user_t usual);
        axi_user_t pick;
        case ({$random(seed)} % 6)
            0:       pick = CPTRA_USER;
            1:       pick = MCU_USER;
            2:       pick = ROGUE_USER;
            default: pick = usual;
        endcase
        pick_user = pick;
    endfunction

    task automatic run_random_seq();
        fuse_addr_t cmds [5];
        axi_user_t  base;
        cmds[0] = `FUSE_CMD_READ;
        cmds[1] = `FUSE_CMD_WRITE;
        cmds[2] = `FUSE_CMD_DIGEST;
        cmds[3] = `FUSE_CMD_ZEROIZE;
        cmds[4] = 32'h0000_0003;
        base = ({$random(seed)} % 2) ? CPTRA_USER : MCU_USER;
        fips = 1'($random(seed));
        run_seq(3'($random(seed)), pick_user(base), pick_user(base), pick_user(base),
                pick_user(base), {$random(seed)} % 32'h900, cmds[{$random(seed)} % 5],
                {$random(seed)} % 2);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        fc_init_done = 1'b0;
        fips         = 1'b0;
        ack          = 1'b0;
        exp_disc     = 1'b0;
        core_wr      = '0;
        seed         = 22864;
        cycles       = 0;
        clear_model();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // The controller is not initialized yet, so even this forbidden zeroize passes.
        run_seq(3'b111, ROGUE_USER, ROGUE_USER, ROGUE_USER, ROGUE_USER, 32'h50,
                `FUSE_CMD_ZEROIZE, 1);
        fc_init_done = 1'b1;
        clear_model();
        tick();

        run_seq(3'b111, MCU_USER, MCU_USER, MCU_USER, MCU_USER, 32'h200, `FUSE_CMD_WRITE, 0);
        run_seq(3'b111, CPTRA_USER, MCU_USER, MCU_USER, MCU_USER, 32'h200, `FUSE_CMD_WRITE, 1);
        // Data word 1 only counts for secret fuses.
        run_seq(3'b111, CPTRA_USER, MCU_USER, CPTRA_USER, CPTRA_USER, 32'h50, `FUSE_CMD_WRITE, 0);
        run_seq(3'b111, CPTRA_USER, MCU_USER, CPTRA_USER, CPTRA_USER, 32'hA0, `FUSE_CMD_WRITE, 0);

        run_seq(3'b100, MCU_USER, MCU_USER, MCU_USER, MCU_USER, 32'h900, `FUSE_CMD_READ, 0);
        run_seq(3'b100, MCU_USER, MCU_USER, CPTRA_USER, CPTRA_USER, 32'h200, `FUSE_CMD_DIGEST, 1);
        run_seq(3'b100, MCU_USER, MCU_USER, CPTRA_USER, MCU_USER, 32'h300, `FUSE_CMD_READ, 0);
        run_seq(3'b100, MCU_USER, MCU_USER, MCU_USER, MCU_USER, 32'h500, `FUSE_CMD_DIGEST, 0);

        run_seq(3'b100, CPTRA_USER, CPTRA_USER, CPTRA_USER, CPTRA_USER, 32'h60,
                `FUSE_CMD_ZEROIZE, 2);
        fips = 1'b1;
        run_seq(3'b100, CPTRA_USER, CPTRA_USER, CPTRA_USER, CPTRA_USER, 32'h60,
                `FUSE_CMD_ZEROIZE, 2);
        fips = 1'b0;

        repeat (N_RANDOM) run_random_seq();
        tick();
        if (dut0.u_fsm.u_chk.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "state machine assertions failed");
        end
    end

endmodule

//--- filelist.f
+incdir+src
src/fuse_filter_pkg.sv
src/fuse_axi_decode.sv
src/fuse_id_tracker.sv
src/fuse_access_table.sv
src/fuse_filter_fsm.sv
src/fuse_filter_top.sv
testbench/fuse_filter_chk.sv
testbench/tb_fuse_filter.sv

//--- Bender.yml
package:
  name: fuse_filter

sources:
  - include_dirs:
      - src
    files:
      - src/fuse_filter_pkg.sv
      - src/fuse_axi_decode.sv
      - src/fuse_id_tracker.sv
      - src/fuse_access_table.sv
      - src/fuse_filter_fsm.sv
      - src/fuse_filter_top.sv
      - target: test
        files:
          - testbench/fuse_filter_chk.sv
          - testbench/tb_fuse_filter.sv
